// File: Bender.yml
package:
  name: core

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - l15_port.sv
  - fetch_unit.sv
  - decode.sv
  - execute.sv
  - result.sv
  - core.sv
  - target: test
    files:
      - core_sva.sv
      - tb_core.sv

// File: all.f
+incdir+.
core_pkg.sv
l15_port.sv
fetch_unit.sv
decode.sv
execute.sv
result.sv
core.sv
core_sva.sv
tb_core.sv

// File: core.sv
`timescale 1ns/10ps
`default_nettype none

module core
(
	input logic clk,
	input logic nrst,
	// L1.5 request side
	output logic [4:0] transducer_l15_rqtype,
	output logic [2:0] transducer_l15_size,
	output logic [31:0] transducer_l15_address,
	output logic [31:0] transducer_l15_data,
	output logic transducer_l15_val,
	input logic l15_transducer_header_ack,
	// L1.5 response side
	input logic l15_transducer_val,
	input logic [63:0] l15_transducer_data_0,
	input logic [63:0] l15_transducer_data_1,
	input logic [31:0] l15_transducer_returntype,
	output logic transducer_l15_req_ack
);

	// Port side
	core_pkg::l15_rsp_t l15_rsp;
	core_pkg::l15_req_t fetch_req;
	core_pkg::l15_req_t data_req;
	logic fetch_req_val;
	logic data_req_val;
	logic fetch_req_done;
	logic data_req_done;
	logic wake;
	logic ifill_val;
	core_pkg::l15_rsp_t ifill;
	logic load_val;
	core_pkg::xlen_t load_data;

	// Pipeline
	core_pkg::insn_t insn;
	logic insn_val;
	core_pkg::dec_op_t op;
	logic op_val;
	logic busy;
	core_pkg::wb_t ex_wb;
	core_pkg::wb_t rs_wb;
	core_pkg::reg_idx_t raddr_a;
	core_pkg::reg_idx_t raddr_b;
	core_pkg::xlen_t rdata_a;
	core_pkg::xlen_t rdata_b;

	// Loose response fields into one beat
	assign l15_rsp = '{
		returntype: l15_transducer_returntype,
		data_0: l15_transducer_data_0,
		data_1: l15_transducer_data_1
	};

	l15_port l15_port_inst
	(
		.clk(clk),
		.nrst(nrst),
		.fetch_req(fetch_req),
		.fetch_req_val(fetch_req_val),
		.data_req(data_req),
		.data_req_val(data_req_val),
		.l15_transducer_header_ack(l15_transducer_header_ack),
		.transducer_l15_rqtype(transducer_l15_rqtype),
		.transducer_l15_size(transducer_l15_size),
		.transducer_l15_address(transducer_l15_address),
		.transducer_l15_data(transducer_l15_data),
		.transducer_l15_val(transducer_l15_val),
		.fetch_req_done(fetch_req_done),
		.data_req_done(data_req_done),
		.l15_rsp(l15_rsp),
		.l15_transducer_val(l15_transducer_val),
		.transducer_l15_req_ack(transducer_l15_req_ack),
		.wake(wake),
		.ifill_val(ifill_val),
		.ifill(ifill),
		.load_val(load_val),
		.load_data(load_data)
	);

	fetch_unit fetch_unit_inst
	(
		.clk(clk),
		.nrst(nrst),
		.wake(wake),
		.ifill_val(ifill_val),
		.ifill(ifill),
		.fetch_req_done(fetch_req_done),
		.busy(busy),
		.fetch_req(fetch_req),
		.fetch_req_val(fetch_req_val),
		.insn(insn),
		.insn_val(insn_val)
	);

	decode decode_inst
	(
		.clk(clk),
		.nrst(nrst),
		.insn(insn),
		.insn_val(insn_val),
		.busy(busy),
		.ex_wb(ex_wb),
		.rs_wb(rs_wb),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.op(op),
		.op_val(op_val)
	);

	execute execute_inst
	(
		.clk(clk),
		.nrst(nrst),
		.op(op),
		.op_val(op_val),
		.data_req_done(data_req_done),
		.load_val(load_val),
		.load_data(load_data),
		.data_req(data_req),
		.data_req_val(data_req_val),
		.busy(busy),
		.ex_wb(ex_wb)
	);

	result result_inst
	(
		.clk(clk),
		.nrst(nrst),
		.ex_wb(ex_wb),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.rs_wb(rs_wb)
	);

endmodule

`default_nettype wire

// File: core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Core geometry
`define CORE_XLEN 32
`define CORE_NREGS 32
`define CORE_RESET_PC 32'h0000_0000
// Instructions per ifill block
`define CORE_BLOCK_INSNS 4

// L1.5 request types
`define L15_RQ_LOAD 5'b00000
`define L15_RQ_STORE 5'b00001
`define L15_RQ_IMISS 5'b10000
// Request sizes
`define L15_SIZE_4B 3'b010
`define L15_SIZE_16B 3'b100

// L1.5 return types, low nibble only
`define L15_RT_LOAD 4'b0000
`define L15_RT_IFILL 4'b0100
`define L15_RT_WAKEUP 4'b0111

// RV32I major opcodes
`define RV_OP_IMM 7'b0010011
`define RV_OP 7'b0110011
`define RV_LOAD 7'b0000011
`define RV_STORE 7'b0100011
// Function fields
`define RV_F3_ADD 3'b000
`define RV_F3_WORD 3'b010
`define RV_F7_BASE 7'b0000000
`define RV_F7_SUB 7'b0100000

`endif

// File: core_pkg.sv
`default_nettype none
`include "core_macros.svh"

package core_pkg;

	// Data word and register index
	typedef logic [`CORE_XLEN-1:0] xlen_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

	// Operation kinds after decode
	typedef enum logic [2:0]
	{
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_LOAD,
		OP_STORE
	} op_e;

	// Fetch FSM
	typedef enum logic [1:0]
	{
		FS_ASLEEP,
		FS_WAIT,
		FS_RUN,
		FS_HALT
	} fetch_state_e;

	// One L1.5 request
	typedef struct packed
	{
		logic [4:0] rqtype;
		logic [2:0] size;
		xlen_t address;
		xlen_t data;
	} l15_req_t;

	// One L1.5 response beat
	typedef struct packed
	{
		logic [31:0] returntype;
		logic [63:0] data_0;
		logic [63:0] data_1;
	} l15_rsp_t;

	// Dispatched instruction
	typedef struct packed
	{
		xlen_t word;
		xlen_t pc;
	} insn_t;

	// Decoded operation with resolved operands
	typedef struct packed
	{
		op_e op;
		reg_idx_t rd;
		xlen_t a;
		xlen_t b;
		xlen_t sdata;
		logic writes_rd;
	} dec_op_t;

	// Register writeback
	typedef struct packed
	{
		logic valid;
		reg_idx_t rd;
		xlen_t value;
	} wb_t;

endpackage

`default_nettype wire

// File: core_sva.sv
`timescale 1ns/10ps
`default_nettype none

module core_sva
(
	input logic clk,
	input logic nrst,
	input logic transducer_l15_val,
	input logic l15_transducer_header_ack,
	input logic [4:0] transducer_l15_rqtype,
	input logic [2:0] transducer_l15_size,
	input logic [31:0] transducer_l15_address,
	input logic [31:0] transducer_l15_data,
	input logic l15_transducer_val,
	input logic transducer_l15_req_ack
);

	// Request held until header_ack
	a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
		(transducer_l15_val && !l15_transducer_header_ack) |=>
		(transducer_l15_val && $stable({transducer_l15_rqtype, transducer_l15_size,
		transducer_l15_address, transducer_l15_data})))
		else $error("L1.5 request changed before header_ack");

	// Single-cycle ack
	a_ack_pulse: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_req_ack |=> !transducer_l15_req_ack)
		else $error("req_ack longer than one cycle");

	// Ack only after a response
	a_ack_cause: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_req_ack |-> $past(l15_transducer_val))
		else $error("req_ack without a response");

endmodule

bind l15_port core_sva core_sva_inst
(
	.clk(clk),
	.nrst(nrst),
	.transducer_l15_val(transducer_l15_val),
	.l15_transducer_header_ack(l15_transducer_header_ack),
	.transducer_l15_rqtype(transducer_l15_rqtype),
	.transducer_l15_size(transducer_l15_size),
	.transducer_l15_address(transducer_l15_address),
	.transducer_l15_data(transducer_l15_data),
	.l15_transducer_val(l15_transducer_val),
	.transducer_l15_req_ack(transducer_l15_req_ack)
);

`default_nettype wire

// File: decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module decode
(
	input logic clk,
	input logic nrst,
	input core_pkg::insn_t insn,
	input logic insn_val,
	input logic busy,
	input core_pkg::wb_t ex_wb,
	input core_pkg::wb_t rs_wb,
	input core_pkg::xlen_t rdata_a,
	input core_pkg::xlen_t rdata_b,
	output core_pkg::reg_idx_t raddr_a,
	output core_pkg::reg_idx_t raddr_b,
	output core_pkg::dec_op_t op,
	output logic op_val
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	core_pkg::xlen_t imm_i;
	core_pkg::xlen_t imm_s;
	core_pkg::xlen_t fwd_a;
	core_pkg::xlen_t fwd_b;
	core_pkg::dec_op_t dec;
	logic b_is_reg;
	logic b_is_reg_q;
	core_pkg::reg_idx_t rs1_q;
	core_pkg::reg_idx_t rs2_q;

	// Nearest writer wins, then the register file
	function automatic core_pkg::xlen_t pick(
		input core_pkg::reg_idx_t ra,
		input core_pkg::xlen_t rf,
		input core_pkg::wb_t near,
		input core_pkg::wb_t far
	);
		if (near.valid && (near.rd == ra))
			return near.value;
		if (far.valid && (far.rd == ra))
			return far.value;
		return rf;
	endfunction

	// Instruction fields
	assign opcode = insn.word[6:0];
	assign funct3 = insn.word[14:12];
	assign funct7 = insn.word[31:25];
	assign raddr_a = insn.word[19:15];
	assign raddr_b = insn.word[24:20];
	assign imm_i = {{(`CORE_XLEN-12){insn.word[31]}}, insn.word[31:20]};
	assign imm_s = {{(`CORE_XLEN-12){insn.word[31]}}, insn.word[31:25], insn.word[11:7]};

	assign fwd_a = pick(raddr_a, rdata_a, ex_wb, rs_wb);
	assign fwd_b = pick(raddr_b, rdata_b, ex_wb, rs_wb);

	always_comb
	begin
		dec = '{op: core_pkg::OP_NOP, rd: insn.word[11:7], a: fwd_a, b: imm_i,
			sdata: fwd_b, writes_rd: 1'b0};
		b_is_reg = 1'b0;
		case (opcode)
			`RV_OP_IMM:
				if (funct3 == `RV_F3_ADD)
					dec.op = core_pkg::OP_ADD;
			`RV_OP:
			begin
				// Register-register, second operand from rs2
				b_is_reg = 1'b1;
				dec.b = fwd_b;
				if ((funct3 == `RV_F3_ADD) && (funct7 == `RV_F7_BASE))
					dec.op = core_pkg::OP_ADD;
				else if ((funct3 == `RV_F3_ADD) && (funct7 == `RV_F7_SUB))
					dec.op = core_pkg::OP_SUB;
			end
			`RV_LOAD:
				if (funct3 == `RV_F3_WORD)
					dec.op = core_pkg::OP_LOAD;
			`RV_STORE:
			begin
				dec.b = imm_s;
				if (funct3 == `RV_F3_WORD)
					dec.op = core_pkg::OP_STORE;
			end
			default:
				dec.op = core_pkg::OP_NOP;
		endcase
		// x0 never written, so it never forwards
		dec.writes_rd = (dec.rd != '0) && ((dec.op == core_pkg::OP_ADD)
			|| (dec.op == core_pkg::OP_SUB) || (dec.op == core_pkg::OP_LOAD));
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
			op_val <= 1'b0;
		else if (!busy)
			op_val <= insn_val;
	end

	always_ff @(posedge clk)
	begin
		if (!busy)
		begin
			op <= dec;
			rs1_q <= raddr_a;
			rs2_q <= raddr_b;
			b_is_reg_q <= b_is_reg;
		end
		else if (ex_wb.valid)
		begin
			// Load return during the hold refreshes stale sources
			if (ex_wb.rd == rs1_q)
				op.a <= ex_wb.value;
			if (ex_wb.rd == rs2_q)
			begin
				op.sdata <= ex_wb.value;
				if (b_is_reg_q)
					op.b <= ex_wb.value;
			end
		end
	end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module execute
(
	input logic clk,
	input logic nrst,
	input core_pkg::dec_op_t op,
	input logic op_val,
	input logic data_req_done,
	input logic load_val,
	input core_pkg::xlen_t load_data,
	output core_pkg::l15_req_t data_req,
	output logic data_req_val,
	output logic busy,
	output core_pkg::wb_t ex_wb
);

	core_pkg::xlen_t sum;
	core_pkg::xlen_t diff;
	logic issue;
	logic is_mem;
	logic ld_wait_q;
	logic ld_wr_q;
	core_pkg::reg_idx_t ld_rd_q;

	// One adder serves ADD and address generation
	assign sum = op.a + op.b;
	assign diff = op.a - op.b;
	assign issue = op_val && !busy;
	assign is_mem = (op.op == core_pkg::OP_LOAD) || (op.op == core_pkg::OP_STORE);

	always_comb
	begin
		ex_wb = '0;
		if (ld_wait_q && load_val)
			ex_wb = '{valid: ld_wr_q, rd: ld_rd_q, value: load_data};
		else if (issue && (op.op == core_pkg::OP_ADD))
			ex_wb = '{valid: op.writes_rd, rd: op.rd, value: sum};
		else if (issue && (op.op == core_pkg::OP_SUB))
			ex_wb = '{valid: op.writes_rd, rd: op.rd, value: diff};
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			busy <= 1'b0;
			data_req_val <= 1'b0;
			ld_wait_q <= 1'b0;
		end
		else
		begin
			if (data_req_done)
			begin
				data_req_val <= 1'b0;
				// Store is finished once the header is taken
				if (!ld_wait_q)
					busy <= 1'b0;
			end
			if (ld_wait_q && load_val)
			begin
				ld_wait_q <= 1'b0;
				busy <= 1'b0;
			end
			if (issue && is_mem)
			begin
				data_req_val <= 1'b1;
				busy <= 1'b1;
				ld_wait_q <= (op.op == core_pkg::OP_LOAD);
			end
		end
	end

	// Request payload and load destination
	always_ff @(posedge clk)
	begin
		if (issue && is_mem)
		begin
			data_req <= '{
				rqtype: (op.op == core_pkg::OP_LOAD) ? `L15_RQ_LOAD : `L15_RQ_STORE,
				size: `L15_SIZE_4B,
				address: sum,
				data: (op.op == core_pkg::OP_STORE) ? op.sdata : '0
			};
			ld_rd_q <= op.rd;
			ld_wr_q <= op.writes_rd;
		end
	end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module fetch_unit
(
	input logic clk,
	input logic nrst,
	input logic wake,
	input logic ifill_val,
	input core_pkg::l15_rsp_t ifill,
	input logic fetch_req_done,
	input logic busy,
	output core_pkg::l15_req_t fetch_req,
	output logic fetch_req_val,
	output core_pkg::insn_t insn,
	output logic insn_val
);

	core_pkg::fetch_state_e state_q;
	core_pkg::xlen_t pc_q;
	core_pkg::xlen_t blk_q [`CORE_BLOCK_INSNS];
	logic have_q;
	logic [`CORE_BLOCK_INSNS*`CORE_XLEN-1:0] line;
	logic [$clog2(`CORE_BLOCK_INSNS)-1:0] slot;
	logic dispatch;

	// Ifill words, lowest first
	assign line = {ifill.data_1, ifill.data_0};
	// Slot in block tracks the PC
	assign slot = pc_q[$clog2(`CORE_BLOCK_INSNS)+1:2];
	assign dispatch = (state_q == core_pkg::FS_RUN) && have_q && !busy;

	// PC stays block aligned whenever a miss goes out
	assign fetch_req = '{rqtype: `L15_RQ_IMISS, size: `L15_SIZE_16B, address: pc_q, data: '0};

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			state_q <= core_pkg::FS_ASLEEP;
			pc_q <= `CORE_RESET_PC;
			have_q <= 1'b0;
			fetch_req_val <= 1'b0;
			insn_val <= 1'b0;
		end
		else
		begin
			if (fetch_req_done)
				fetch_req_val <= 1'b0;
			// Strobe holds only while the pipe is stalled
			if (!busy)
				insn_val <= dispatch;
			case (state_q)
				core_pkg::FS_ASLEEP:
				begin
					if (wake)
					begin
						fetch_req_val <= 1'b1;
						state_q <= core_pkg::FS_WAIT;
					end
				end
				core_pkg::FS_WAIT:
				begin
					if (ifill_val)
					begin
						have_q <= 1'b1;
						state_q <= core_pkg::FS_RUN;
					end
				end
				core_pkg::FS_RUN:
				begin
					if (dispatch)
					begin
						pc_q <= pc_q + 32'd4;
						// Last slot empties the buffer
						if (slot == '1)
							have_q <= 1'b0;
						// All-zero word halts
						if (blk_q[slot] == '0)
							state_q <= core_pkg::FS_HALT;
					end
					else if (!have_q && !busy)
					begin
						fetch_req_val <= 1'b1;
						state_q <= core_pkg::FS_WAIT;
					end
				end
				default:
				begin
				end
			endcase
		end
	end

	// Block buffer and dispatched word
	always_ff @(posedge clk)
	begin
		if (ifill_val && (state_q == core_pkg::FS_WAIT))
			for (int i = 0; i < `CORE_BLOCK_INSNS; i++)
				blk_q[i] <= line[i*`CORE_XLEN +: `CORE_XLEN];
		if (dispatch)
			insn <= '{word: blk_q[slot], pc: pc_q};
	end

endmodule

`default_nettype wire

// File: l15_port.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module l15_port
(
	input logic clk,
	input logic nrst,
	// Requesters
	input core_pkg::l15_req_t fetch_req,
	input logic fetch_req_val,
	input core_pkg::l15_req_t data_req,
	input logic data_req_val,
	// L1.5 request side
	input logic l15_transducer_header_ack,
	output logic [4:0] transducer_l15_rqtype,
	output logic [2:0] transducer_l15_size,
	output logic [31:0] transducer_l15_address,
	output logic [31:0] transducer_l15_data,
	output logic transducer_l15_val,
	output logic fetch_req_done,
	output logic data_req_done,
	// L1.5 response side
	input core_pkg::l15_rsp_t l15_rsp,
	input logic l15_transducer_val,
	output logic transducer_l15_req_ack,
	output logic wake,
	output logic ifill_val,
	output core_pkg::l15_rsp_t ifill,
	output logic load_val,
	output core_pkg::xlen_t load_data
);

	core_pkg::l15_req_t req_q;
	logic req_val_q;
	logic sel_data_q;
	logic req_ack_q;
	logic accept;
	logic load_slot;
	logic data_next;
	logic fetch_next;
	logic [3:0] rtype;

	// Held request taken on header_ack
	assign accept = req_val_q && l15_transducer_header_ack;
	assign fetch_req_done = accept && !sel_data_q;
	assign data_req_done = accept && sel_data_q;

	// Slot opens when idle or on the accepting edge
	assign load_slot = !req_val_q || accept;
	// A source just accepted still shows its level this cycle, so skip it
	assign data_next = data_req_val && !data_req_done;
	assign fetch_next = fetch_req_val && !fetch_req_done;

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			req_val_q <= 1'b0;
			sel_data_q <= 1'b0;
		end
		else if (load_slot)
		begin
			// Data side has fixed priority
			req_val_q <= data_next || fetch_next;
			sel_data_q <= data_next;
		end
	end

	// Request payload, stable while val is up
	always_ff @(posedge clk)
	begin
		if (load_slot)
			req_q <= data_next ? data_req : fetch_req;
	end

	assign transducer_l15_val = req_val_q;
	assign transducer_l15_rqtype = req_q.rqtype;
	assign transducer_l15_size = req_q.size;
	assign transducer_l15_address = req_q.address;
	assign transducer_l15_data = req_q.data;

	// Response classification
	assign rtype = l15_rsp.returntype[3:0];
	assign wake = l15_transducer_val && (rtype == `L15_RT_WAKEUP);
	assign ifill_val = l15_transducer_val && (rtype == `L15_RT_IFILL);
	assign ifill = l15_rsp;
	assign load_val = l15_transducer_val && (rtype == `L15_RT_LOAD);
	// Load word sits in the low half of data_0
	assign load_data = l15_rsp.data_0[`CORE_XLEN-1:0];

	// One ack pulse the cycle after each response
	always_ff @(posedge clk)
	begin
		if (!nrst)
			req_ack_q <= 1'b0;
		else
			req_ack_q <= l15_transducer_val;
	end

	assign transducer_l15_req_ack = req_ack_q;

endmodule

`default_nettype wire

// File: result.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module result
(
	input logic clk,
	input logic nrst,
	input core_pkg::wb_t ex_wb,
	input core_pkg::reg_idx_t raddr_a,
	input core_pkg::reg_idx_t raddr_b,
	output core_pkg::xlen_t rdata_a,
	output core_pkg::xlen_t rdata_b,
	output core_pkg::wb_t rs_wb
);

	core_pkg::xlen_t regs [`CORE_NREGS];

	// Writes to x0 dropped
	always_ff @(posedge clk)
	begin
		if (ex_wb.valid && (ex_wb.rd != '0))
			regs[ex_wb.rd] <= ex_wb.value;
	end

	// x0 reads as zero
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

	// Last writeback, kept one more cycle for forwarding
	always_ff @(posedge clk)
	begin
		if (!nrst)
			rs_wb.valid <= 1'b0;
		else
			rs_wb <= ex_wb;
	end

endmodule

`default_nettype wire

// File: tb_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module tb_core;

	// Expected request with its operation kind
	typedef struct packed
	{
		core_pkg::op_e kind;
		core_pkg::l15_req_t req;
	} row_t;

	logic clk;
	logic nrst;
	logic [4:0] rqtype;
	logic [2:0] size;
	logic [31:0] address;
	logic [31:0] wdata;
	logic req_val;
	logic header_ack;
	logic rsp_val;
	logic [63:0] data_0;
	logic [63:0] data_1;
	logic [31:0] returntype;
	logic req_ack;

	integer seed;
	int cycles;
	int limit;
	int plen;
	logic [31:0] prog [0:31];
	logic [31:0] dmem [0:63];
	logic [31:0] gregs [0:31];
	row_t rows [$];

	core core_inst
	(
		.clk(clk),
		.nrst(nrst),
		.transducer_l15_rqtype(rqtype),
		.transducer_l15_size(size),
		.transducer_l15_address(address),
		.transducer_l15_data(wdata),
		.transducer_l15_val(req_val),
		.l15_transducer_header_ack(header_ack),
		.l15_transducer_val(rsp_val),
		.l15_transducer_data_0(data_0),
		.l15_transducer_data_1(data_1),
		.l15_transducer_returntype(returntype),
		.transducer_l15_req_ack(req_ack)
	);

	always #10 clk = ~clk;

	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_req(input string name, input core_pkg::l15_req_t got,
		input core_pkg::l15_req_t exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_kind(input string name, input core_pkg::op_e got,
		input core_pkg::op_e exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// Request type back to an operation kind
	// Fetches count as NOP
	function automatic core_pkg::op_e kind_of(input logic [4:0] rt);
		if (rt == `L15_RQ_LOAD)
			return core_pkg::OP_LOAD;
		if (rt == `L15_RQ_STORE)
			return core_pkg::OP_STORE;
		return core_pkg::OP_NOP;
	endfunction

	// Appends a word
	// A new block brings its own miss
	task automatic put(input logic [31:0] word);
		if (plen % `CORE_BLOCK_INSNS == 0)
			rows.push_back('{core_pkg::OP_NOP, '{`L15_RQ_IMISS, `L15_SIZE_16B,
				`CORE_RESET_PC + plen * 4, 32'h0}});
		prog[plen] = word;
		plen++;
	endtask

	task automatic addi(input int rd, input int rs1, input int imm);
		put({imm[11:0], rs1[4:0], `RV_F3_ADD, rd[4:0], `RV_OP_IMM});
		if (rd != 0)
			gregs[rd] = gregs[rs1] + imm;
	endtask

	task automatic arith(input logic sub, input int rd, input int rs1, input int rs2);
		put({sub ? `RV_F7_SUB : `RV_F7_BASE, rs2[4:0], rs1[4:0], `RV_F3_ADD, rd[4:0], `RV_OP});
		if (rd != 0)
			gregs[rd] = sub ? gregs[rs1] - gregs[rs2] : gregs[rs1] + gregs[rs2];
	endtask

	task automatic sw(input int rs2, input int rs1, input int imm);
		put({imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, imm[4:0], `RV_STORE});
		rows.push_back('{core_pkg::OP_STORE, '{`L15_RQ_STORE, `L15_SIZE_4B,
			gregs[rs1] + imm, gregs[rs2]}});
	endtask

	task automatic lw(input int rd, input int rs1, input int imm);
		logic [31:0] ea;
		ea = gregs[rs1] + imm;
		put({imm[11:0], rs1[4:0], `RV_F3_WORD, rd[4:0], `RV_LOAD});
		rows.push_back('{core_pkg::OP_LOAD, '{`L15_RQ_LOAD, `L15_SIZE_4B, ea, 32'h0}});
		gregs[rd] = dmem[ea[7:2]];
	endtask

	task automatic build_program();
		plen = 0;
		for (int i = 0; i < 32; i++)
			prog[i] = '0;
		for (int i = 0; i < 64; i++)
			dmem[i] = i * 32'h9e37_79b1 + 32'h0001_2345;
		gregs[0] = '0;
		// Back-to-back dependences
		addi(1, 0, 5);
		addi(2, 1, 7);
		arith(1'b1, 3, 2, 1);
		addi(0, 0, 0);
		sw(3, 0, 'h100);
		repeat (3) addi(0, 0, 0);
		// Same chain with spacers
		addi(4, 0, 5);
		repeat (2) addi(0, 0, 0);
		addi(5, 4, 7);
		repeat (2) addi(0, 0, 0);
		arith(1'b1, 6, 5, 4);
		repeat (3) addi(0, 0, 0);
		sw(6, 0, 'h104);
		addi(0, 0, 0);
		// Load, use, store
		lw(7, 0, 'h80);
		arith(1'b0, 8, 7, 1);
		sw(8, 0, 'h108);
		addi(0, 0, 0);
		// Halt block
		repeat (4) put(32'h0);
	endtask

	task automatic send_response(input logic [3:0] rt, input logic [63:0] d0,
		input logic [63:0] d1);
		@(posedge clk);
		rsp_val <= 1'b1;
		returntype <= {28'h0, rt};
		data_0 <= d0;
		data_1 <= d1;
		@(posedge clk);
		rsp_val <= 1'b0;
		@(negedge clk);
		check_bit("transducer_l15_req_ack", req_ack, 1'b1);
		@(negedge clk);
		check_bit("transducer_l15_req_ack", req_ack, 1'b0);
	endtask

	task automatic serve_request(input row_t row);
		core_pkg::l15_req_t got;
		int base;
		do
			@(negedge clk);
		while (!req_val);
		got = '{rqtype, size, address, wdata};
		check_kind("request kind", kind_of(got.rqtype), row.kind);
		check_req("l15 request", got, row.req);
		repeat ({$random(seed)} % 4) @(negedge clk);
		@(posedge clk);
		header_ack <= 1'b1;
		@(posedge clk);
		header_ack <= 1'b0;
		base = got.address[6:2];
		if (row.kind == core_pkg::OP_NOP)
			send_response(`L15_RT_IFILL, {prog[base+1], prog[base]},
				{prog[base+3], prog[base+2]});
		else if (row.kind == core_pkg::OP_LOAD)
		begin
			repeat ({$random(seed)} % 4) @(posedge clk);
			send_response(`L15_RT_LOAD, {32'h0, dmem[got.address[7:2]]}, 64'h0);
		end
	endtask

	// Run limit scales with the request table
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("Timeout after %0d cycles waiting for the core", cycles);
			stop_on_error();
		end
	end

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		header_ack = 1'b0;
		rsp_val = 1'b0;
		data_0 = '0;
		data_1 = '0;
		returntype = '0;
		seed = 54115;
		cycles = 0;
		build_program();
		limit = 200 * rows.size();
		repeat (16) @(posedge clk);
		nrst <= 1'b1;
		// Asleep until woken
		repeat (10)
		begin
			@(negedge clk);
			check_bit("transducer_l15_val", req_val, 1'b0);
		end
		send_response(`L15_RT_WAKEUP, 64'h0, 64'h0);
		foreach (rows[i])
			serve_request(rows[i]);
		// Halted core stays quiet
		repeat (100)
		begin
			@(negedge clk);
			if (req_val)
			begin
				$display("Request seen at t=%0t after the halt word", $time);
				stop_on_error();
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
